/* sources.f */
+incdir+.
mipsPkg.sv
mipsAlu.sv
mipsRegFile.sv
mipsDatapath.sv
mipsController.sv
mipsCore.sv
tbMipsCore.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f sources.f --top-module tbMipsCore -o simMipsCore; then
   echo "verilator build failed"
   exit 1
fi

simOut=$(./obj_dir/simMipsCore)
simStatus=$?
echo "$simOut"
if [ "$simStatus" -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if echo "$simOut" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1

/* tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ======================================================================
// instruction encoders
// ======================================================================

function automatic word_t encR(input logic [5:0] funct, input regAddr_t rd,
                               input regAddr_t rs, input regAddr_t rt);
   return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic word_t encI(input logic [5:0] op, input regAddr_t rt,
                               input regAddr_t rs, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic word_t encJ(input logic [5:0] op, input logic [25:0] index);
   return {op, index};
endfunction

localparam int    progWords  = 61;
localparam int    jalIndex   = 53;
localparam word_t dataBase   = 32'h0000_0400;
localparam word_t poisonAddr = 32'h0000_07f0;
localparam word_t doneAddr   = 32'h0000_07fc;

// ======================================================================
// program image, one word per line
// ======================================================================

localparam word_t progImage [progWords] = '{
   encI(6'h0f, 5'd1, 5'd0, 16'h8000),     // lui   r1, 0x8000
   encI(6'h0d, 5'd1, 5'd1, 16'h0001),     // ori   r1, r1, 1
   encI(6'h09, 5'd2, 5'd0, 16'h0005),     // addiu r2, r0, 5
   encI(6'h08, 5'd3, 5'd0, 16'hfffd),     // addi  r3, r0, -3
   encR(6'h20, 5'd4, 5'd1, 5'd2),         // add   r4, r1, r2
   encI(6'h2b, 5'd4, 5'd0, 16'h0400),     // sw    r4, 0x400
   encR(6'h21, 5'd5, 5'd2, 5'd3),         // addu  r5, r2, r3
   encI(6'h2b, 5'd5, 5'd0, 16'h0404),
   encR(6'h22, 5'd6, 5'd2, 5'd3),         // sub   r6, r2, r3
   encI(6'h2b, 5'd6, 5'd0, 16'h0408),
   encR(6'h23, 5'd7, 5'd3, 5'd2),         // subu  r7, r3, r2
   encI(6'h2b, 5'd7, 5'd0, 16'h040c),
   encR(6'h24, 5'd8, 5'd1, 5'd3),         // and   r8, r1, r3
   encI(6'h2b, 5'd8, 5'd0, 16'h0410),
   encR(6'h25, 5'd9, 5'd1, 5'd2),         // or    r9, r1, r2
   encI(6'h2b, 5'd9, 5'd0, 16'h0414),
   encR(6'h26, 5'd10, 5'd1, 5'd3),        // xor   r10, r1, r3
   encI(6'h2b, 5'd10, 5'd0, 16'h0418),
   encR(6'h27, 5'd11, 5'd1, 5'd2),        // nor   r11, r1, r2
   encI(6'h2b, 5'd11, 5'd0, 16'h041c),
   encR(6'h2a, 5'd12, 5'd1, 5'd2),        // slt   r12, r1, r2 (overflowing compare)
   encI(6'h2b, 5'd12, 5'd0, 16'h0420),
   encR(6'h2b, 5'd13, 5'd1, 5'd2),        // sltu  r13, r1, r2
   encI(6'h2b, 5'd13, 5'd0, 16'h0424),
   encI(6'h0a, 5'd14, 5'd3, 16'hfffe),    // slti  r14, r3, -2
   encI(6'h2b, 5'd14, 5'd0, 16'h0428),
   encI(6'h0b, 5'd15, 5'd2, 16'hffff),    // sltiu r15, r2, -1
   encI(6'h2b, 5'd15, 5'd0, 16'h042c),
   encI(6'h0c, 5'd16, 5'd3, 16'hfff0),    // andi  r16, r3, 0xfff0
   encI(6'h2b, 5'd16, 5'd0, 16'h0430),
   encI(6'h0d, 5'd17, 5'd2, 16'h8000),    // ori   r17, r2, 0x8000
   encI(6'h2b, 5'd17, 5'd0, 16'h0434),
   encI(6'h0e, 5'd18, 5'd3, 16'hffff),    // xori  r18, r3, 0xffff
   encI(6'h2b, 5'd18, 5'd0, 16'h0438),
   encI(6'h08, 5'd19, 5'd2, 16'hfff9),    // addi  r19, r2, -7
   encI(6'h2b, 5'd19, 5'd0, 16'h043c),
   encI(6'h2b, 5'd4, 5'd0, 16'h0440),     // round trip through memory
   encI(6'h23, 5'd21, 5'd0, 16'h0440),    // lw    r21, 0x440
   encI(6'h2b, 5'd21, 5'd0, 16'h0444),
   encI(6'h0f, 5'd22, 5'd0, 16'h1234),    // lui   r22, 0x1234
   encI(6'h2b, 5'd22, 5'd0, 16'h0448),
   encI(6'h09, 5'd0, 5'd0, 16'h0055),     // addiu r0, r0, 0x55
   encI(6'h2b, 5'd0, 5'd0, 16'h044c),
   encI(6'h04, 5'd2, 5'd2, 16'h0001),     // beq   r2, r2 taken
   encI(6'h2b, 5'd2, 5'd0, 16'h07f0),     // poison
   encI(6'h04, 5'd3, 5'd2, 16'h0001),     // beq   r2, r3 not taken
   encI(6'h2b, 5'd2, 5'd0, 16'h0450),
   encI(6'h05, 5'd3, 5'd2, 16'h0001),     // bne   r2, r3 taken
   encI(6'h2b, 5'd2, 5'd0, 16'h07f0),     // poison
   encI(6'h05, 5'd2, 5'd2, 16'h0001),     // bne   r2, r2 not taken
   encI(6'h2b, 5'd3, 5'd0, 16'h0454),
   encJ(6'h02, 26'd53),                   // j     to the jal
   encI(6'h2b, 5'd2, 5'd0, 16'h07f0),     // poison
   encJ(6'h03, 26'd57),                   // jal   subroutine
   encI(6'h2b, 5'd31, 5'd0, 16'h0458),    // link value, after the return
   encJ(6'h02, 26'd60),                   // j     to the done store
   encI(6'h2b, 5'd2, 5'd0, 16'h07f0),     // poison
   encI(6'h2b, 5'd2, 5'd0, 16'h045c),     // subroutine body
   encR(6'h08, 5'd0, 5'd31, 5'd0),        // jr    r31
   encI(6'h2b, 5'd2, 5'd0, 16'h07f0),     // poison
   encI(6'h2b, 5'd0, 5'd0, 16'h07fc)      // done
};

// expected words at dataBase onward, one per store
localparam int    expectWords = 24;
localparam word_t expectValue [expectWords] = '{
   32'h8000_0006, 32'h0000_0002, 32'h0000_0008, 32'hffff_fff8,
   32'h8000_0001, 32'h8000_0005, 32'h7fff_fffc, 32'h7fff_fffa,
   32'h0000_0001, 32'h0000_0000, 32'h0000_0001, 32'h0000_0001,
   32'h0000_fff0, 32'h0000_8005, 32'hffff_0002, 32'hffff_fffe,
   32'h8000_0006, 32'h8000_0006, 32'h1234_0000, 32'h0000_0000,
   32'h0000_0005, 32'hffff_fffd, word_t'(jalIndex * 4 + 4), 32'h0000_0005
};

`endif

/* tbMipsCore.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mipsCore_config.svh"

module tbMipsCore import mipsPkg::*; ();

`include "tbProgram.svh"

   localparam int memWords      = 512;
   localparam int timeoutCycles = progWords * 9 + 50;

   logic    clk;
   logic    reset;
   word_t   memReadData;
   memReq_t memReq;

   word_t mem [memWords];
   logic  written [expectWords];
   int    expectIndex;
   logic  expectValid;
   word_t expectData;
   word_t lastAddr;
   logic  lastRead;
   logic  doneSeen;
   int    cycles;
   int    errorCount;
   int    storeCount;

   mipsCore u_dut (
      .clk         (clk),
      .reset       (reset),
      .memReadData (memReadData),
      .memReq      (memReq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ======================================================================
   // memory model and bookkeeping
   // ======================================================================

   // reads are combinational, writes land on the clock edge
   assign memReadData = mem[memReq.addr[10:2]];

   always @(posedge clk) begin
      if (memReq.write)
         mem[memReq.addr[10:2]] <= memReq.writeData;
   end

   always_comb begin
      expectIndex = int'((memReq.addr - dataBase) >> 2);
      expectValid = (memReq.addr >= dataBase) && (expectIndex < expectWords)
                    && (memReq.addr[1:0] == 2'b00);
      expectData  = expectValid ? expectValue[expectIndex] : '0;
   end

   always @(posedge clk) begin
      cycles   <= cycles + 1;
      lastAddr <= memReq.addr;
      lastRead <= memReq.read;
      if (memReq.write && expectValid) begin
         written[expectIndex] <= 1'b1;
         storeCount           <= storeCount + 1;
      end
      if (memReq.write && memReq.addr == doneAddr)
         doneSeen <= 1'b1;
   end

   // ======================================================================
   // protocol and result checks
   // ======================================================================

   assert property (@(posedge clk) (reset && cycles >= 1) |-> !memReq.write)
      else begin
         errorCount++;
         $display("[ERROR] memReq.write in reset: got %h expected 0", $sampled(memReq.write));
      end

   assert property (@(posedge clk) $fell(reset) |-> !memReq.write && !memReq.read)
      else begin
         errorCount++;
         $display("[ERROR] memReq.read/write after reset: got %h/%h expected 0/0",
                  $sampled(memReq.read), $sampled(memReq.write));
      end

   // first fetch comes from the reset vector
   assert property (@(posedge clk) $fell(reset) |=>
                    memReq.read && memReq.addr == `MIPS_RESET_PC)
      else begin
         errorCount++;
         $display("[ERROR] memReq.addr first fetch: got %h expected %h (read %h)",
                  $sampled(memReq.addr), `MIPS_RESET_PC, $sampled(memReq.read));
      end

   assert property (@(posedge clk) disable iff (reset) memReq.write |=> !memReq.write)
      else begin
         errorCount++;
         $display("write strobe stayed high longer than one cycle");
      end

   assert property (@(posedge clk) disable iff (reset) !(memReq.read && memReq.write))
      else begin
         errorCount++;
         $display("read and write strobes were high in the same cycle");
      end

   assert property (@(posedge clk) disable iff (reset)
                    (memReq.read && lastRead) |-> memReq.addr == lastAddr)
      else begin
         errorCount++;
         $display("[ERROR] memReq.addr moved under read: got %h expected %h",
                  $sampled(memReq.addr), $sampled(lastAddr));
      end

   assert property (@(posedge clk) disable iff (reset)
                    (memReq.write && expectValid) |-> memReq.writeData == expectData)
      else begin
         errorCount++;
         $display("[ERROR] memReq.writeData at %h: got %h expected %h",
                  $sampled(memReq.addr), $sampled(memReq.writeData), $sampled(expectData));
      end

   // wrong branch or jump paths land here
   assert property (@(posedge clk) disable iff (reset)
                    memReq.write |-> memReq.addr != poisonAddr)
      else begin
         errorCount++;
         $display("store to the poison address, a wrong path was executed");
      end

   assert property (@(posedge clk) disable iff (reset) memReq.write |->
                    (expectValid || memReq.addr == poisonAddr || memReq.addr == doneAddr))
      else begin
         errorCount++;
         $display("store to an address outside the result table: %h", $sampled(memReq.addr));
      end

   // ======================================================================
   // run control
   // ======================================================================

   initial begin
      reset       = 1'b1;
      doneSeen    = 1'b0;
      cycles      = 0;
      errorCount  = 0;
      storeCount  = 0;
      lastRead    = 1'b0;
      lastAddr    = '0;
      for (int i = 0; i < memWords; i++)
         mem[i] = 32'h5a5a_0000 ^ word_t'(i * 4);   // fill follows the byte address
      for (int i = 0; i < progWords; i++)
         mem[i] = progImage[i];
      for (int i = 0; i < expectWords; i++)
         written[i] = 1'b0;

      repeat (5) @(posedge clk);
      reset <= 1'b0;

      while (!doneSeen && cycles < timeoutCycles)
         @(posedge clk);
      if (!doneSeen) begin
         errorCount++;
         $display("timeout after %0d cycles without the done store", cycles);
      end
      @(posedge clk);

      foreach (written[i])
         assert (written[i]) else begin
            errorCount++;
            $display("no store ever reached result address %h", dataBase + 4 * i);
         end

      $display("errors: %0d, result stores: %0d of %0d", errorCount, storeCount, expectWords);
      if (errorCount == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/1ns
`default_nettype none

module mipsCore import mipsPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  word_t   memReadData,
   output memReq_t memReq
);

   dpCtrl_t ctrl;
   word_t   instr;
   logic    aluZero;

   mipsController u_controller (
      .clk     (clk),
      .reset   (reset),
      .instr   (instr),
      .aluZero (aluZero),
      .ctrl    (ctrl)
   );

   mipsDatapath u_datapath (
      .clk         (clk),
      .reset       (reset),
      .ctrl        (ctrl),
      .memReadData (memReadData),
      .instr       (instr),
      .aluZero     (aluZero),
      .memReq      (memReq)
   );

endmodule

`default_nettype wire

/* mipsController.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mipsCore_config.svh"

module mipsController import mipsPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  word_t   instr,
   input  logic    aluZero,
   output dpCtrl_t ctrl
);

   localparam int WaitBits = $clog2(`MIPS_MEM_WAIT + 1);

   ctrlState_t state, nextState;
   logic [WaitBits-1:0] waitCnt;
   logic    waitDone;
   logic    goFetch;
   opcode_t opcode;
   logic [5:0] funct;

   assign opcode   = instr[31:26];
   assign funct    = instr[5:0];
   assign waitDone = (waitCnt == WaitBits'(`MIPS_MEM_WAIT - 1));

   always_ff @(posedge clk) begin
      if (reset)
         state <= stReset;
      else
         state <= nextState;
   end

   // counts only while parked in a memory wait state
   always_ff @(posedge clk) begin
      if (reset || (state != stFetchWait && state != stLwWait))
         waitCnt <= '0;
      else
         waitCnt <= waitCnt + 1'b1;
   end

   always_comb begin
      ctrl      = '0;
      nextState = state;
      goFetch   = 1'b0;

      case (state)
         stReset: goFetch = 1'b1;

         stFetchWait:
            if (waitDone) nextState = stFetchCap;

         stFetchCap: begin   // IR <= mem, PC <= PC + 4
            ctrl.irWrite = 1'b1;
            ctrl.pcWrite = 1'b1;
            ctrl.clrRead = 1'b1;
            ctrl.aluSelB = 3'd1;
            nextState    = stDecode;
         end

         stDecode: begin
            ctrl.aWrite     = 1'b1;
            ctrl.bWrite     = 1'b1;
            ctrl.signExtend = 1'b1;
            ctrl.aluSelB    = 3'd3;   // branch target on the ALU
            case (opcode)
               opRType:
                  case (funct)
                     6'h08:                      nextState = stJrJump;
                     6'h20, 6'h21, 6'h22, 6'h23,
                     6'h24, 6'h25, 6'h26, 6'h27,
                     6'h2a, 6'h2b:               nextState = stExAluR;
                     default:                    goFetch   = 1'b1;
                  endcase
               opAddi, opAddiu, opSlti, opSltiu,
               opAndi, opOri, opXori: nextState = stExAluI;
               opLw:                  nextState = stLwAddr;
               opSw:                  nextState = stSwAddr;
               opLui:                 nextState = stLui;
               opBeq, opBne:          nextState = stBrCmp;
               opJ:                   nextState = stJump;
               opJal:                 nextState = stJalLink;
               default:               goFetch   = 1'b1;   // unknown, skip
            endcase
         end

         stExAluR: begin
            ctrl.aluSelA = 2'd1;
            ctrl.aluSelB = 3'd0;
            case (funct)
               6'h22, 6'h23: ctrl.aluOp = aluSub;
               6'h24:        ctrl.aluOp = aluAnd;
               6'h25:        ctrl.aluOp = aluOr;
               6'h26:        ctrl.aluOp = aluXor;
               6'h27:        ctrl.aluOp = aluNor;
               6'h2a:        ctrl.aluOp = aluSlt;
               6'h2b:        ctrl.aluOp = aluSltu;
               default:      ctrl.aluOp = aluAdd;
            endcase
            ctrl.rfWrite = 1'b1;
            ctrl.regDst  = 2'd1;
            goFetch      = 1'b1;
         end

         stExAluI: begin
            ctrl.aluSelA = 2'd1;
            ctrl.aluSelB = 3'd2;
            case (opcode)
               opSlti:  ctrl.aluOp = aluSlt;
               opSltiu: ctrl.aluOp = aluSltu;
               opAndi:  ctrl.aluOp = aluAnd;
               opOri:   ctrl.aluOp = aluOr;
               opXori:  ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAdd;
            endcase
            // logical immediates are zero extended
            ctrl.signExtend = !(opcode inside {opAndi, opOri, opXori});
            ctrl.rfWrite    = 1'b1;
            goFetch         = 1'b1;
         end

         stLwAddr, stSwAddr: begin
            ctrl.marWrite    = 1'b1;
            ctrl.addrFromAlu = 1'b1;
            ctrl.signExtend  = 1'b1;
            ctrl.aluSelA     = 2'd1;
            ctrl.aluSelB     = 3'd2;
            ctrl.setRead     = (state == stLwAddr);
            ctrl.setWrite    = (state == stSwAddr);
            nextState        = (state == stLwAddr) ? stLwWait : stSwRelease;
         end

         stLwWait:
            if (waitDone) nextState = stLwCap;

         stLwCap: begin
            ctrl.mdrWrite = 1'b1;
            ctrl.clrRead  = 1'b1;
            nextState     = stLwWb;
         end

         stLwWb: begin
            ctrl.rfWrite = 1'b1;
            ctrl.wbSel   = 2'd1;
            goFetch      = 1'b1;
         end

         stSwRelease: begin   // write pulse is this cycle
            ctrl.clrWrite = 1'b1;
            nextState     = stSwFinish;
         end

         stSwFinish: goFetch = 1'b1;

         stLui: begin
            ctrl.rfWrite = 1'b1;
            ctrl.wbSel   = 2'd2;
            goFetch      = 1'b1;
         end

         stBrCmp: begin
            ctrl.aluSelA = 2'd1;
            ctrl.aluSelB = 3'd0;
            ctrl.aluOp   = aluSub;
            if (aluZero == (opcode == opBeq))
               nextState = stBrTake;
            else
               goFetch = 1'b1;
         end

         stBrTake, stJump, stJalJump, stJrJump: begin
            ctrl.pcWrite     = 1'b1;
            ctrl.marWrite    = 1'b1;
            ctrl.addrFromAlu = 1'b1;
            ctrl.setRead     = 1'b1;
            ctrl.signExtend  = 1'b1;
            case (state)
               stBrTake: ctrl.aluSelB = 3'd3;   // PC + offset
               stJrJump: begin
                  ctrl.aluSelA = 2'd1;
                  ctrl.aluSelB = 3'd5;           // rs + 0
               end
               default: begin
                  ctrl.aluSelA = 2'd2;
                  ctrl.aluSelB = 3'd4;
               end
            endcase
            nextState = (state == stJrJump) ? stJrFinish : stFetchWait;
         end

         stJalLink: begin   // r31 <= PC, already PC + 4
            ctrl.aluSelA = 2'd0;
            ctrl.aluSelB = 3'd5;
            ctrl.regDst  = 2'd2;
            ctrl.rfWrite = 1'b1;
            nextState    = stJalJump;
         end

         stJrFinish: goFetch = 1'b1;

         default: nextState = stReset;
      endcase

      // common tail: MAR <= PC and start the next fetch
      if (goFetch) begin
         ctrl.marWrite    = 1'b1;
         ctrl.addrFromAlu = 1'b0;
         ctrl.setRead     = 1'b1;
         nextState        = stFetchWait;
      end
   end

   // capture follows exactly MIPS_MEM_WAIT cycles of waiting
   assert property (@(posedge clk) disable iff (reset)
                    (state == stFetchCap || state == stLwCap) |->
                       ($past(state, `MIPS_MEM_WAIT) == $past(state)
                        && $past(state, `MIPS_MEM_WAIT + 1) != $past(state)))
      else $error("memory wait before state %0d was not %0d cycles", state, `MIPS_MEM_WAIT);

endmodule

`default_nettype wire

/* mipsDatapath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mipsCore_config.svh"

module mipsDatapath import mipsPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  dpCtrl_t ctrl,
   input  word_t   memReadData,
   output word_t   instr,
   output logic    aluZero,
   output memReq_t memReq
);

   word_t pc, ir, regA, regB, mdr, mar;
   logic  readStrobe, writeStrobe;

   word_t    aluA, aluB, aluResult;
   word_t    rfDataA, rfDataB, rfWriteData;
   regAddr_t rfWriteAddr;
   word_t    immExt, jumpTarget;

   // ======================================================================
   // instruction fields
   // ======================================================================

   assign immExt = ctrl.signExtend ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
   assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

   // ======================================================================
   // registers
   // ======================================================================

   always_ff @(posedge clk) begin
      if (reset)
         pc <= `MIPS_RESET_PC;
      else if (ctrl.pcWrite)
         pc <= aluResult;
   end

   always_ff @(posedge clk) begin
      if (ctrl.irWrite)  ir   <= memReadData;
      if (ctrl.mdrWrite) mdr  <= memReadData;
      if (ctrl.aWrite)   regA <= rfDataA;
      if (ctrl.bWrite)   regB <= rfDataB;
      if (ctrl.marWrite)
         mar <= ctrl.addrFromAlu ? aluResult : pc;
   end

   // memory strobes, clear wins over set
   always_ff @(posedge clk) begin
      if (reset || ctrl.clrRead)
         readStrobe <= 1'b0;
      else if (ctrl.setRead)
         readStrobe <= 1'b1;

      if (reset || ctrl.clrWrite)
         writeStrobe <= 1'b0;
      else if (ctrl.setWrite)
         writeStrobe <= 1'b1;
   end

   // ======================================================================
   // operand muxes and ALU
   // ======================================================================

   always_comb begin
      case (ctrl.aluSelA)
         2'd0:    aluA = pc;
         2'd1:    aluA = regA;
         default: aluA = '0;
      endcase
   end

   always_comb begin
      case (ctrl.aluSelB)
         3'd0:    aluB = regB;
         3'd1:    aluB = 32'd4;
         3'd2:    aluB = immExt;
         3'd3:    aluB = {immExt[29:0], 2'b00};
         3'd4:    aluB = jumpTarget;
         default: aluB = '0;    // pass A through
      endcase
   end

   mipsAlu u_alu (
      .op     (ctrl.aluOp),
      .a      (aluA),
      .b      (aluB),
      .result (aluResult),
      .zero   (aluZero)
   );

   // ======================================================================
   // register file and write-back
   // ======================================================================

   always_comb begin
      case (ctrl.regDst)
         2'd0:    rfWriteAddr = ir[20:16];
         2'd1:    rfWriteAddr = ir[15:11];
         default: rfWriteAddr = 5'd31;    // link register
      endcase
   end

   always_comb begin
      case (ctrl.wbSel)
         2'd0:    rfWriteData = aluResult;
         2'd1:    rfWriteData = mdr;
         default: rfWriteData = {ir[15:0], 16'h0000};
      endcase
   end

   mipsRegFile u_regFile (
      .clk       (clk),
      .rfWrite   (ctrl.rfWrite),
      .readAddrA (ir[25:21]),
      .readAddrB (ir[20:16]),
      .writeAddr (rfWriteAddr),
      .writeData (rfWriteData),
      .readDataA (rfDataA),
      .readDataB (rfDataB)
   );

   assign instr  = ir;
   assign memReq = '{addr: mar, writeData: regB, read: readStrobe, write: writeStrobe};

   // the controller must never overlap a store with a pending read
   assert property (@(posedge clk) disable iff (reset) !(readStrobe && writeStrobe))
      else $error("read and write strobes high together");

endmodule

`default_nettype wire

/* mipsRegFile.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mipsCore_config.svh"

module mipsRegFile import mipsPkg::*; (
   input  logic     clk,
   input  logic     rfWrite,
   input  regAddr_t readAddrA,
   input  regAddr_t readAddrB,
   input  regAddr_t writeAddr,
   input  word_t    writeData,
   output word_t    readDataA,
   output word_t    readDataB
);

   word_t regs [`MIPS_REG_COUNT];

   always_ff @(posedge clk) begin
      if (rfWrite && writeAddr != '0)   // r0 is never written
         regs[writeAddr] <= writeData;
   end

   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* mipsAlu.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mipsCore_config.svh"

module mipsAlu import mipsPkg::*; (
   input  aluOp_t op,
   input  word_t  a,
   input  word_t  b,
   output word_t  result,
   output logic   zero
);

   logic   sub;
   word_t  bOperand;
   logic [`MIPS_WORD_BITS:0] sum;
   logic   overflow;
   logic   lessSigned;
   logic   lessUnsigned;

   // one adder, subtract by inverting b and carrying in
   assign sub      = (op != aluAdd);
   assign bOperand = sub ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, bOperand} + {{`MIPS_WORD_BITS{1'b0}}, sub};

   assign overflow = (a[`MIPS_WORD_BITS-1] != b[`MIPS_WORD_BITS-1])
                   && (sum[`MIPS_WORD_BITS-1] != a[`MIPS_WORD_BITS-1]);
   assign lessSigned   = overflow ^ sum[`MIPS_WORD_BITS-1];
   assign lessUnsigned = ~sum[`MIPS_WORD_BITS];   // no carry out means borrow

   always_comb begin
      case (op)
         aluAdd,
         aluSub:  result = sum[`MIPS_WORD_BITS-1:0];
         aluSlt:  result = {{(`MIPS_WORD_BITS-1){1'b0}}, lessSigned};
         aluSltu: result = {{(`MIPS_WORD_BITS-1){1'b0}}, lessUnsigned};
         aluAnd:  result = a & b;
         aluOr:   result = a | b;
         aluXor:  result = a ^ b;
         aluNor:  result = ~(a | b);
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);

   // branch decisions need a zero difference to mean equal operands
   always_comb begin
      if (op == aluSub)
         assert final (zero == (a == b))
            else $error("alu zero flag %b for operands %h and %h", zero, a, b);
   end

endmodule

`default_nettype wire

/* mipsPkg.sv */
`default_nettype none
`include "mipsCore_config.svh"

package mipsPkg;

   typedef logic [`MIPS_WORD_BITS-1:0] word_t;
   typedef logic [4:0] regAddr_t;
   typedef logic [5:0] opcode_t;

   // primary opcodes used by the decoder
   localparam opcode_t opRType = 6'h00;
   localparam opcode_t opJ     = 6'h02;
   localparam opcode_t opJal   = 6'h03;
   localparam opcode_t opBeq   = 6'h04;
   localparam opcode_t opBne   = 6'h05;
   localparam opcode_t opAddi  = 6'h08;
   localparam opcode_t opAddiu = 6'h09;
   localparam opcode_t opSlti  = 6'h0a;
   localparam opcode_t opSltiu = 6'h0b;
   localparam opcode_t opAndi  = 6'h0c;
   localparam opcode_t opOri   = 6'h0d;
   localparam opcode_t opXori  = 6'h0e;
   localparam opcode_t opLui   = 6'h0f;
   localparam opcode_t opLw    = 6'h23;
   localparam opcode_t opSw    = 6'h2b;

   typedef enum logic [2:0] {
      aluAdd, aluSub, aluSlt, aluSltu, aluAnd, aluXor, aluOr, aluNor
   } aluOp_t;

   typedef enum logic [4:0] {
      stReset, stFetchWait, stFetchCap, stDecode,
      stExAluR, stExAluI,
      stLwAddr, stLwWait, stLwCap, stLwWb,
      stSwAddr, stSwRelease, stSwFinish,
      stLui, stBrCmp, stBrTake, stJump,
      stJalLink, stJalJump, stJrJump, stJrFinish
   } ctrlState_t;

   typedef struct packed {
      logic pcWrite, aWrite, bWrite, irWrite, mdrWrite, marWrite, rfWrite;
      logic setRead, clrRead, setWrite, clrWrite;
      logic addrFromAlu;       // MAR from ALU, else from PC
      logic signExtend;
      logic [1:0] aluSelA;     // 0 PC, 1 A, 2 zero
      logic [2:0] aluSelB;     // 0 B, 1 four, 2 imm, 3 imm<<2, 4 jump, else zero
      aluOp_t aluOp;
      logic [1:0] regDst;      // 0 rt, 1 rd, 2 r31
      logic [1:0] wbSel;       // 0 alu, 1 mdr, 2 lui
   } dpCtrl_t;

   typedef struct packed {
      word_t addr;
      word_t writeData;
      logic  read;
      logic  write;
   } memReq_t;

endpackage

`default_nettype wire

/* mipsCore_config.svh */
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// ======================================================================
// core geometry
// ======================================================================

// data and address width
`define MIPS_WORD_BITS 32

// architectural registers
`define MIPS_REG_COUNT 32

// ======================================================================
// memory port and reset
// ======================================================================

// cycles between raising read and the data being valid
`define MIPS_MEM_WAIT 2

// first fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif
